//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing
TOP      := mul_unit_tb
FILELIST := build.f

BUILD    := obj_dir
SIM      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuild the simulator only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- build.f
rtl/mul_pkg.sv
rtl/mul_skid_buffer.sv
rtl/mul_dispatch.sv
rtl/mul_lane.sv
rtl/mul_collect.sv
rtl/mul_unit.sv
verification/tb_clock_gen.sv
verification/mul_unit_tb.sv

//--- rtl/mul_collect.sv
// In-order response collector
`timescale 1ns/1ps

module mul_collect import mul_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     lane_valid [NUM_LANES],
  input  mul_rsp_t lane_rsp   [NUM_LANES],
  output logic     lane_ready [NUM_LANES],
  output logic     out_valid,
  output mul_rsp_t out_rsp,
  input  logic     out_ready
);

  // Lane that owes the oldest outstanding result
  logic [LANE_IDX_WIDTH-1:0] ptr;
  logic                      out_fire;

  // A result from the other lane waits until this lane has delivered
  assign out_valid = lane_valid[ptr];
  assign out_rsp   = lane_rsp[ptr];
  assign out_fire  = out_valid && out_ready;

  // Ready reaches only the selected lane, the others keep stalling
  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      lane_ready[i] = out_ready && (ptr == LANE_IDX_WIDTH'(i));
    end
  end

  // Same walk as the dispatcher, so the order of requests is restored
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ptr <= '0;
    end
    else if (out_fire)
    begin
      if (ptr == LANE_IDX_WIDTH'(NUM_LANES - 1))
      begin
        ptr <= '0;
      end
      else
      begin
        ptr <= ptr + LANE_IDX_WIDTH'(1);
      end
    end
  end

endmodule

//--- rtl/mul_dispatch.sv
// Round-robin request dispatcher
`timescale 1ns/1ps

module mul_dispatch import mul_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  mul_req_t in_req,
  output logic     in_ready,
  output logic     lane_valid [NUM_LANES],
  output mul_req_t lane_req   [NUM_LANES],
  input  logic     lane_ready [NUM_LANES]
);

  // Lane that receives the next request
  logic [LANE_IDX_WIDTH-1:0] ptr;
  logic                      in_fire;

  // Only the selected lane sees valid, the payload goes to all of them
  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      lane_valid[i] = in_valid && (ptr == LANE_IDX_WIDTH'(i));
      lane_req[i]   = in_req;
    end
  end

  // A stalled lane blocks issue instead of being skipped
  // Skipping would let the collector see results out of order
  assign in_ready = lane_ready[ptr];
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ptr <= '0;
    end
    else if (in_fire)
    begin
      // Step to the next lane and wrap after the last one
      if (ptr == LANE_IDX_WIDTH'(NUM_LANES - 1))
      begin
        ptr <= '0;
      end
      else
      begin
        ptr <= ptr + LANE_IDX_WIDTH'(1);
      end
    end
  end

endmodule

//--- rtl/mul_lane.sv
// Pipelined nibble multiplier lane
`timescale 1ns/1ps

module mul_lane import mul_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  mul_req_t in_req,
  output logic     in_ready,
  output logic     out_valid,
  output mul_rsp_t out_rsp,
  input  logic     out_ready
);

  // Stage 1 holds the operands
  logic                  s1_valid;
  logic [TAG_WIDTH-1:0]  s1_tag;
  logic [WORD_WIDTH-1:0] s1_a;
  logic [WORD_WIDTH-1:0] s1_b;
  // Stages 2 to 5 hold the partial products and the tree levels
  logic                  s2_valid;
  logic [TAG_WIDTH-1:0]  s2_tag;
  logic [PROD_WIDTH-1:0] s2_pp [NUM_PARTIALS];
  logic                  s3_valid;
  logic [TAG_WIDTH-1:0]  s3_tag;
  logic [PROD_WIDTH-1:0] s3_sum [NUM_PARTIALS/2];
  logic                  s4_valid;
  logic [TAG_WIDTH-1:0]  s4_tag;
  logic [PROD_WIDTH-1:0] s4_sum [NUM_PARTIALS/4];
  logic                  s5_valid;
  logic [TAG_WIDTH-1:0]  s5_tag;
  logic [PROD_WIDTH-1:0] s5_sum [NUM_PARTIALS/8];
  // Stage 6 holds the finished response
  logic                  s6_valid;
  mul_rsp_t              s6_rsp;
  logic [PROD_WIDTH-1:0] full_prod;
  logic                  adv;

  // One digit-by-digit product placed at its weight in the full product
  function automatic logic [PROD_WIDTH-1:0] nib_product(
    input logic [NIBBLE_WIDTH-1:0] x,
    input logic [NIBBLE_WIDTH-1:0] y,
    input int unsigned             pos
  );
    logic [PROD_WIDTH-1:0] p;
    p = PROD_WIDTH'(x) * PROD_WIDTH'(y);
    return p << (NIBBLE_WIDTH * pos);
  endfunction

  // The whole pipe moves together when the last stage can be emptied
  assign adv      = !s6_valid || out_ready;
  assign in_ready = adv;

  // Eight-term sum of the last tree level gives the full 64-bit product
  always_comb
  begin
    full_prod = '0;
    for (int k = 0; k < NUM_PARTIALS/8; k++)
    begin
      full_prod = full_prod + s5_sum[k];
    end
  end

  // Valid bits march with the data and are the only state under reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
      s4_valid <= 1'b0;
      s5_valid <= 1'b0;
      s6_valid <= 1'b0;
    end
    else if (adv)
    begin
      s1_valid <= in_valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
      s4_valid <= s3_valid;
      s5_valid <= s4_valid;
      s6_valid <= s5_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (adv)
    begin
      s1_tag <= in_req.tag;
      s1_a   <= in_req.multiplicand;
      s1_b   <= in_req.multiplier;
      // Digit i of a times digit j of b carries weight 16**(i+j)
      for (int i = 0; i < NUM_NIBBLES; i++)
      begin
        for (int j = 0; j < NUM_NIBBLES; j++)
        begin
          s2_pp[i*NUM_NIBBLES + j] <= nib_product(s1_a[i*NIBBLE_WIDTH +: NIBBLE_WIDTH],
                                                  s1_b[j*NIBBLE_WIDTH +: NIBBLE_WIDTH],
                                                  i + j);
        end
      end
      s2_tag <= s1_tag;
      // Pairwise adder tree, one level per stage
      for (int i = 0; i < NUM_PARTIALS/2; i++)
      begin
        s3_sum[i] <= s2_pp[2*i] + s2_pp[2*i + 1];
      end
      s3_tag <= s2_tag;
      for (int i = 0; i < NUM_PARTIALS/4; i++)
      begin
        s4_sum[i] <= s3_sum[2*i] + s3_sum[2*i + 1];
      end
      s4_tag <= s3_tag;
      for (int i = 0; i < NUM_PARTIALS/8; i++)
      begin
        s5_sum[i] <= s4_sum[2*i] + s4_sum[2*i + 1];
      end
      s5_tag <= s4_tag;
      // Low half is the result, any bit set in the high half is overflow
      s6_rsp.tag      <= s5_tag;
      s6_rsp.result   <= full_prod[WORD_WIDTH-1:0];
      s6_rsp.overflow <= |full_prod[PROD_WIDTH-1:WORD_WIDTH];
    end
  end

  assign out_valid = s6_valid;
  assign out_rsp   = s6_rsp;

endmodule

//--- rtl/mul_pkg.sv
// Multiply unit shared definitions

package mul_pkg;

  // Operand and result width of the unit
  localparam int WORD_WIDTH = 32;

  // Digit width used for the partial products
  localparam int NIBBLE_WIDTH = 4;

  // Digits per operand, eight for a 32-bit word
  localparam int NUM_NIBBLES = WORD_WIDTH / NIBBLE_WIDTH;

  // Full unsigned product width, twice the operand width
  localparam int PROD_WIDTH = 2 * WORD_WIDTH;

  // One partial product per digit pair, 64 in all
  localparam int NUM_PARTIALS = NUM_NIBBLES * NUM_NIBBLES;

  // Parallel multiplier lanes behind the dispatcher
  localparam int NUM_LANES = 2;

  // Request identifier width, echoed back with each result
  localparam int TAG_WIDTH = 4;

  // Round-robin pointer width for dispatcher and collector
  localparam int LANE_IDX_WIDTH = 1;

  // Request as it enters the unit
  // The tag is the top field so it is easy to spot in waveforms
  typedef struct packed {
    logic [TAG_WIDTH-1:0]  tag;
    logic [WORD_WIDTH-1:0] multiplicand;
    logic [WORD_WIDTH-1:0] multiplier;
  } mul_req_t;

  // Response as it leaves the unit
  // Result is the low half of the unsigned product
  // Overflow flags a non-zero high half
  typedef struct packed {
    logic [TAG_WIDTH-1:0]  tag;
    logic [WORD_WIDTH-1:0] result;
    logic                  overflow;
  } mul_rsp_t;

endpackage

//--- rtl/mul_skid_buffer.sv
// Two-entry skid buffer
`timescale 1ns/1ps

module mul_skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  // The main register feeds the consumer
  // The spill register catches an item that arrives while the consumer stalls
  logic     main_valid;
  payload_t main_data;
  logic     spill_valid;
  payload_t spill_data;
  logic     in_fire;
  logic     out_fire;
  logic     main_free;

  assign in_fire  = in_valid && in_ready;
  assign out_fire = main_valid && out_ready;

  // Main register can be reloaded when it is empty or being drained
  assign main_free = !main_valid || out_fire;

  // Ready only depends on a flop, so no combinational path runs upstream
  assign in_ready  = !spill_valid;
  assign out_valid = main_valid;
  assign out_data  = main_data;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      main_valid  <= 1'b0;
      spill_valid <= 1'b0;
    end
    else if (main_free)
    begin
      // Spilled item has priority, input is blocked while spill is full
      main_valid  <= spill_valid || in_fire;
      spill_valid <= 1'b0;
    end
    else if (in_fire)
    begin
      // Consumer stalled with main full, park the new item
      spill_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (main_free)
    begin
      main_data <= spill_valid ? spill_data : in_data;
    end
    if (!main_free && in_fire)
    begin
      spill_data <= in_data;
    end
  end

endmodule

//--- rtl/mul_unit.sv
// Pipelined multiply unit top
`timescale 1ns/1ps

module mul_unit import mul_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  mul_req_t in_req,
  output logic     in_ready,
  output logic     out_valid,
  output mul_rsp_t out_rsp,
  input  logic     out_ready
);

  // Registered request feeding the dispatcher
  logic     req_valid;
  mul_req_t req_data;
  logic     req_ready;

  // Per-lane request and response links
  logic     lane_in_valid  [NUM_LANES];
  mul_req_t lane_in_req    [NUM_LANES];
  logic     lane_in_ready  [NUM_LANES];
  logic     lane_out_valid [NUM_LANES];
  mul_rsp_t lane_out_rsp   [NUM_LANES];
  logic     lane_out_ready [NUM_LANES];

  // Ordered response stream before the output register
  logic     rsp_valid;
  mul_rsp_t rsp_data;
  logic     rsp_ready;

  // Input boundary register, keeps in_ready off the lane stall path
  mul_skid_buffer #(
    .payload_t (mul_req_t)
  ) req_buf_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_data   (in_req),
    .in_ready  (in_ready),
    .out_valid (req_valid),
    .out_data  (req_data),
    .out_ready (req_ready)
  );

  mul_dispatch dispatch_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (req_valid),
    .in_req     (req_data),
    .in_ready   (req_ready),
    .lane_valid (lane_in_valid),
    .lane_req   (lane_in_req),
    .lane_ready (lane_in_ready)
  );

  // Identical lanes, each taking every NUM_LANES-th request
  for (genvar g = 0; g < NUM_LANES; g++)
  begin : g_lane
    mul_lane lane_i (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (lane_in_valid[g]),
      .in_req    (lane_in_req[g]),
      .in_ready  (lane_in_ready[g]),
      .out_valid (lane_out_valid[g]),
      .out_rsp   (lane_out_rsp[g]),
      .out_ready (lane_out_ready[g])
    );
  end

  mul_collect collect_i (
    .clk        (clk),
    .rst        (rst),
    .lane_valid (lane_out_valid),
    .lane_rsp   (lane_out_rsp),
    .lane_ready (lane_out_ready),
    .out_valid  (rsp_valid),
    .out_rsp    (rsp_data),
    .out_ready  (rsp_ready)
  );

  // Output boundary register, keeps out_ready off the lane stall path
  mul_skid_buffer #(
    .payload_t (mul_rsp_t)
  ) rsp_buf_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (rsp_valid),
    .in_data   (rsp_data),
    .in_ready  (rsp_ready),
    .out_valid (out_valid),
    .out_data  (out_rsp),
    .out_ready (out_ready)
  );

endmodule

//--- verification/mul_unit_tb.sv
// Multiply unit testbench
`timescale 1ns/1ps

module mul_unit_tb import mul_pkg::*; ();

  localparam int CLK_PERIOD_NS   = 20;
  localparam int RESET_CYCLES    = 4;
  localparam int NUM_VECTORS     = 16;
  localparam int NUM_STREAM      = 24;
  localparam int NUM_BACKPRESS   = 24;
  localparam int NUM_RANDOM      = NUM_STREAM + NUM_BACKPRESS;
  localparam int TOTAL_REQS      = NUM_VECTORS + NUM_RANDOM;
  // Input buffer, six lane stages and output buffer
  localparam int UNIT_LATENCY    = 8;
  localparam int DRAIN_LIMIT     = 300;
  localparam int WATCHDOG_CYCLES = TOTAL_REQS * UNIT_LATENCY + 400;

  // One row of the directed table with its hand-worked answer
  typedef struct packed {
    logic [WORD_WIDTH-1:0] a;
    logic [WORD_WIDTH-1:0] b;
    logic [WORD_WIDTH-1:0] result;
    logic                  overflow;
  } vector_t;

  // Scoreboard entry that keeps the accepting cycle for latency checks
  typedef struct packed {
    mul_rsp_t    rsp;
    logic [31:0] acc_cycle;
    logic        timed;
  } expect_t;

  logic     clk;
  logic     rst;
  logic     in_valid;
  mul_req_t in_req;
  logic     in_ready;
  logic     out_valid;
  mul_rsp_t out_rsp;
  logic     out_ready;

  integer                seed;
  int                    errors;
  int                    checks;
  int                    stall_count;
  int unsigned           cycle = 0;
  logic [TAG_WIDTH-1:0]  next_tag;
  logic                  bp_mode;
  logic                  bp_filled;
  logic [WORD_WIDTH-1:0] rand_a [NUM_RANDOM];
  logic [WORD_WIDTH-1:0] rand_b [NUM_RANDOM];
  expect_t               exp_q [$];

  // Columns are multiplicand, multiplier, low half of product, overflow
  vector_t vectors [NUM_VECTORS] = '{
    '{32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0},
    '{32'h0000_0001, 32'h0000_0001, 32'h0000_0001, 1'b0},
    '{32'h0000_0001, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0},
    '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001, 1'b1},
    '{32'h0001_0000, 32'h0001_0000, 32'h0000_0000, 1'b1},
    '{32'h0000_FFFF, 32'h0000_FFFF, 32'hFFFE_0001, 1'b0},
    '{32'h8000_0000, 32'h0000_0002, 32'h0000_0000, 1'b1},
    '{32'h8000_0000, 32'h0000_0001, 32'h8000_0000, 1'b0},
    '{32'h0000_0007, 32'h0000_0009, 32'h0000_003F, 1'b0},
    '{32'h1234_5678, 32'h0000_0010, 32'h2345_6780, 1'b1},
    '{32'h0000_0100, 32'h00AB_CDEF, 32'hABCD_EF00, 1'b0},
    '{32'hFFFF_FFFF, 32'h0000_0002, 32'hFFFF_FFFE, 1'b1},
    '{32'h0001_0001, 32'h0000_FFFF, 32'hFFFF_FFFF, 1'b0},
    '{32'h0001_0001, 32'h0001_0000, 32'h0001_0000, 1'b1},
    '{32'h0000_0003, 32'h5555_5556, 32'h0000_0002, 1'b1}
  };

  tb_clock_gen #(
    .PERIOD_NS (CLK_PERIOD_NS)
  ) clock_i (
    .clk (clk)
  );

  mul_unit mul_unit_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_rsp   (out_rsp),
    .out_ready (out_ready)
  );

  // Exact unsigned product in 64 bits split into the result and overflow fields
  function automatic mul_rsp_t expected_rsp(input logic [TAG_WIDTH-1:0] tag,
                                            input logic [WORD_WIDTH-1:0] a,
                                            input logic [WORD_WIDTH-1:0] b);
    logic [2*WORD_WIDTH-1:0] prod;
    mul_rsp_t                rsp;
    prod         = {{WORD_WIDTH{1'b0}}, a} * {{WORD_WIDTH{1'b0}}, b};
    rsp.tag      = tag;
    rsp.result   = prod[WORD_WIDTH-1:0];
    rsp.overflow = |prod[2*WORD_WIDTH-1:WORD_WIDTH];
    return rsp;
  endfunction

  // Holds one request on the input until it is taken and then books the answer
  task automatic send_req(input logic [WORD_WIDTH-1:0] a, input logic [WORD_WIDTH-1:0] b,
                          input mul_rsp_t exp_rsp, input logic timed);
    expect_t entry;
    in_valid <= 1'b1;
    in_req   <= '{tag: exp_rsp.tag, multiplicand: a, multiplier: b};
    @(posedge clk);
    while (!in_ready)
    begin
      stall_count++;
      @(posedge clk);
    end
    entry.rsp       = exp_rsp;
    entry.acc_cycle = cycle;
    entry.timed     = timed;
    exp_q.push_back(entry);
  endtask

  // Waits for the scoreboard to empty and flags whatever never came back
  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_LIMIT)
    begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      errors++;
      $display("Lost responses: %0d expected responses never arrived by time %0t",
               exp_q.size(), $time);
      exp_q.delete();
    end
  endtask

  // Compares one output transfer against the oldest booked answer
  task automatic check_response();
    expect_t e;
    if (exp_q.size() == 0)
    begin
      errors++;
      $display("Unexpected response with tag %0h at time %0t, nothing was outstanding",
               out_rsp.tag, $time);
    end
    else
    begin
      e = exp_q.pop_front();
      checks++;
      if (out_rsp.tag !== e.rsp.tag)
      begin
        errors++;
        $display("Error: time %0t, out_rsp.tag expected %h, got %h",
                 $time, e.rsp.tag, out_rsp.tag);
      end
      if (out_rsp.result !== e.rsp.result)
      begin
        errors++;
        $display("Error: time %0t, out_rsp.result expected %h, got %h",
                 $time, e.rsp.result, out_rsp.result);
      end
      if (out_rsp.overflow !== e.rsp.overflow)
      begin
        errors++;
        $display("Error: time %0t, out_rsp.overflow expected %b, got %b",
                 $time, e.rsp.overflow, out_rsp.overflow);
      end
      // Latency counts rising edges from acceptance to the output transfer
      if (e.timed && int'(cycle - e.acc_cycle) != UNIT_LATENCY)
      begin
        errors++;
        $display("Error: time %0t, out_valid latency expected %0d, got %0d",
                 $time, UNIT_LATENCY, int'(cycle - e.acc_cycle));
      end
    end
  endtask

  task automatic report_and_finish();
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
  end

  // Values read here are the ones the DUT sampled on the same edge
  always @(posedge clk)
  begin
    if (!rst && out_valid && out_ready)
    begin
      check_response();
    end
  end

  // Back-pressure holds out_ready low until the unit fills and then toggles it
  always @(posedge clk)
  begin
    if (!bp_mode)
    begin
      out_ready <= 1'b1;
    end
    else if (!bp_filled)
    begin
      out_ready <= 1'b0;
      if (in_valid && !in_ready)
      begin
        bp_filled <= 1'b1;
      end
    end
    else
    begin
      out_ready <= ($random(seed) & 32'sd1) != 0;
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    errors++;
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    report_and_finish();
  end

  initial
  begin
    seed        = 32'hd2fd220d;
    rst         = 1'b1;
    in_valid    = 1'b0;
    in_req      = '0;
    out_ready   = 1'b0;
    bp_mode     = 1'b0;
    bp_filled   = 1'b0;
    errors      = 0;
    checks      = 0;
    stall_count = 0;
    next_tag    = '0;
    // All random operands are drawn before the clock matters
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      rand_a[i] = $random(seed);
      rand_b[i] = $random(seed);
    end

    // The first edge still shows the power-up state of the output register
    for (int i = 0; i < RESET_CYCLES; i++)
    begin
      @(posedge clk);
      if (i > 0 && out_valid !== 1'b0)
      begin
        errors++;
        $display("Error: time %0t, out_valid expected 0, got %b", $time, out_valid);
      end
    end
    rst <= 1'b0;
    @(posedge clk);
    checks++;
    if (in_ready !== 1'b1)
    begin
      errors++;
      $display("Error: time %0t, in_ready expected 1, got %b", $time, in_ready);
    end
    if (out_valid !== 1'b0)
    begin
      errors++;
      $display("Error: time %0t, out_valid expected 0, got %b", $time, out_valid);
    end

    // Directed table with one isolated request at a time
    for (int i = 0; i < NUM_VECTORS; i++)
    begin
      send_req(vectors[i].a, vectors[i].b,
               '{tag: next_tag, result: vectors[i].result, overflow: vectors[i].overflow},
               1'b1);
      in_valid <= 1'b0;
      next_tag = next_tag + TAG_WIDTH'(1);
      wait_drain();
    end

    // Back-to-back stream where the unit should never stall with out_ready high
    stall_count = 0;
    for (int i = 0; i < NUM_STREAM; i++)
    begin
      send_req(rand_a[i], rand_b[i], expected_rsp(next_tag, rand_a[i], rand_b[i]), 1'b1);
      next_tag = next_tag + TAG_WIDTH'(1);
    end
    in_valid <= 1'b0;
    if (stall_count != 0)
    begin
      errors++;
      $display("in_ready dropped %0d times while streaming with out_ready held high",
               stall_count);
    end
    wait_drain();

    // Same stream against a slow consumer
    bp_mode <= 1'b1;
    for (int i = NUM_STREAM; i < NUM_RANDOM; i++)
    begin
      send_req(rand_a[i], rand_b[i], expected_rsp(next_tag, rand_a[i], rand_b[i]), 1'b0);
      next_tag = next_tag + TAG_WIDTH'(1);
    end
    in_valid <= 1'b0;
    wait_drain();
    if (!bp_filled)
    begin
      errors++;
      $display("in_ready never fell while out_ready was held low");
    end
    bp_mode <= 1'b0;

    // A few idle cycles catch duplicated responses
    repeat (10) @(posedge clk);
    report_and_finish();
  end

endmodule

//--- verification/tb_clock_gen.sv
// Testbench clock source
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  // Clock starts low so the first rising edge lands half a period in
  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

endmodule
